// File: Makefile
# Verilator build for the keyboard to display project

TOOL       ?= verilator
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
TOP        ?= kbd_seg_tb
RTL_TOP    ?= kbd_seg_top
FILELIST   ?= kbd_seg_soc.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := >>> PASS

.PHONY: all lint sim clean

all: sim

# lint the design top, then the whole bench
lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the log
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -Fxq '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: kbd_seg_soc.f
logic/kbd_seg_pkg.sv
logic/ps2_kbd.sv
logic/key_ctrl.sv
logic/seg_shift.sv
logic/kbd_seg_top.sv
tb/kbd_seg_sva.sv
tb/kbd_seg_tb.sv

// File: logic/kbd_seg_pkg.sv
// shared widths, ps/2 scan codes and segment font; referenced by scoped name from rtl and testbench
package kbd_seg_pkg;

    // one scan code byte from the keyboard
    localparam int kb_width = 8;

    // display word, four make codes of eight bits
    localparam int seg_width = 32;

    // seven segments plus decimal point per digit
    localparam int digit_bits = 8;

    // break prefix, the byte after it is a release
    localparam logic [kb_width-1:0] code_break = 8'hF0;

    // extended key prefix
    localparam logic [kb_width-1:0] code_ext = 8'hE0;

    // hex nibble to active-low pattern, bit 7 is dp (kept dark), bits 6..0 are g..a
    function automatic logic [digit_bits-1:0] seg_font(input logic [3:0] nib);
        logic [6:0] lit;
        // active-high gfedcba first, inverted on return
        case (nib)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return {1'b1, ~lit};
    endfunction

endpackage

// File: logic/kbd_seg_top.sv
// keyboard to display top level; ps/2 receiver feeds the key controller which drives leds and display
`timescale 1ns/1ps

module kbd_seg_top #(
    parameter int fifo_depth = 8,
    parameter int seg_div    = 4
) (
    input  logic                               clk200m,
    input  logic                               rst_n,
    input  logic                               ps2_clk,
    input  logic                               ps2_data,
    output logic [kbd_seg_pkg::kb_width-1:0]   leds,
    output logic                               seg_clk,
    output logic                               seg_clr_n,
    output logic                               seg_dout,
    output logic                               seg_en
);

    // queue head and handshake
    logic [kbd_seg_pkg::kb_width-1:0]  kb_data;
    logic                              kb_ready;
    logic                              rd_kb_n;

    // last four make codes
    logic [kbd_seg_pkg::seg_width-1:0] seg_wdata;

    ps2_kbd #(
        .fifo_depth (fifo_depth)
    ) u_ps2_kbd (
        .clk200m    (clk200m),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .rd_kb_n    (rd_kb_n),
        .kb_data    (kb_data),
        .kb_ready   (kb_ready)
    );

    // stands where the cpu used to read the keyboard
    key_ctrl u_key_ctrl (
        .clk200m    (clk200m),
        .rst_n      (rst_n),
        .kb_data    (kb_data),
        .kb_ready   (kb_ready),
        .rd_kb_n    (rd_kb_n),
        .seg_wdata  (seg_wdata),
        .leds       (leds)
    );

    // free-running refresh, own prescaler
    seg_shift #(
        .seg_div    (seg_div)
    ) u_seg_shift (
        .clk200m    (clk200m),
        .rst_n      (rst_n),
        .seg_wdata  (seg_wdata),
        .seg_clk    (seg_clk),
        .seg_clr_n  (seg_clr_n),
        .seg_dout   (seg_dout),
        .seg_en     (seg_en)
    );

endmodule

// File: logic/key_ctrl.sv
// key controller; drains the scan code queue, drops break and extended prefixes, keeps last four makes
`timescale 1ns/1ps

module key_ctrl (
    input  logic                               clk200m,
    input  logic                               rst_n,
    input  logic [kbd_seg_pkg::kb_width-1:0]   kb_data,
    input  logic                               kb_ready,
    output logic                               rd_kb_n,
    output logic [kbd_seg_pkg::seg_width-1:0]  seg_wdata,
    output logic [kbd_seg_pkg::kb_width-1:0]   leds
);

    // strobe issued last cycle
    logic rd_prev;
    // set by a break prefix, swallows the released key code
    logic skip;

    // strobe whenever a byte waits, at most every other cycle
    // so the queue head has settled after the previous pop
    assign rd_kb_n = ~(kb_ready & ~rd_prev);

    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            rd_prev <= 1'b0;
        end else begin
            rd_prev <= ~rd_kb_n;
        end
    end

    // byte is taken in the strobe cycle
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            skip      <= 1'b0;
            seg_wdata <= '0;
        end else if (!rd_kb_n) begin
            if (skip) begin
                // released key, ignore and rearm
                skip <= 1'b0;
            end else if (kb_data == kbd_seg_pkg::code_break) begin
                skip <= 1'b1;
            end else if (kb_data == kbd_seg_pkg::code_ext) begin
                // prefix only, the code after it is a normal make
                skip <= 1'b0;
            end else begin
                // newest make code enters at the low byte
                seg_wdata <= {seg_wdata[kbd_seg_pkg::seg_width-kbd_seg_pkg::kb_width-1:0],
                              kb_data};
            end
        end
    end

    // leds follow the newest make code
    assign leds = seg_wdata[kbd_seg_pkg::kb_width-1:0];

endmodule

// File: logic/ps2_kbd.sv
// ps/2 keyboard receiver; decodes 11-bit frames and queues good bytes for a strobed reader
`timescale 1ns/1ps

module ps2_kbd #(
    parameter int fifo_depth = 8
) (
    input  logic                               clk200m,
    input  logic                               rst_n,
    input  logic                               ps2_clk,
    input  logic                               ps2_data,
    input  logic                               rd_kb_n,
    output logic [kbd_seg_pkg::kb_width-1:0]   kb_data,
    output logic                               kb_ready
);

    // fifo_depth must be a power of two, at least 2
    localparam int ptr_w = $clog2(fifo_depth);

    // [0],[1] synchronizer stages, [2] previous synced level for edge detect
    logic [2:0]                             clk_sync;
    logic [1:0]                             data_sync;
    logic                                   ps2_fall;
    logic [3:0]                             bit_cnt;
    // start, d0..d7, parity in arrival order, lsb first
    logic [9:0]                             frame;
    logic                                   frame_ok;
    logic                                   push;
    logic                                   pop;
    logic [kbd_seg_pkg::kb_width-1:0]       mem [fifo_depth];
    logic [ptr_w-1:0]                       wr_ptr;
    logic [ptr_w-1:0]                       rd_ptr;
    logic [ptr_w:0]                         count;

    // lines idle high, so sync flops reset to one
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 3'b111;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // keyboard drives data on its falling clock
    assign ps2_fall = clk_sync[2] & ~clk_sync[1];

    // bit position within the frame, 0..10
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (ps2_fall) begin
            if (bit_cnt == 4'd10) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // payload shift register
    always_ff @(posedge clk200m) begin
        if (ps2_fall) begin
            frame <= {data_sync[1], frame[9:1]};
        end
    end

    // start low, odd parity over data and parity bit, stop (current sample) high
    assign frame_ok = ~frame[0] & (^frame[9:1]) & data_sync[1];

    // store on the stop bit edge, drop bad frames and frames hitting a full queue
    assign push = ps2_fall && (bit_cnt == 4'd10) && frame_ok
                  && (count != (ptr_w + 1)'(fifo_depth));

    // reader may only strobe while a byte waits
    assign pop = ~rd_kb_n & kb_ready;

    always_ff @(posedge clk200m) begin
        if (push) begin
            mem[wr_ptr] <= frame[8:1];
        end
    end

    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // net occupancy change
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // first word fall through, head always visible
    assign kb_data  = mem[rd_ptr];
    assign kb_ready = (count != '0);

endmodule

// File: logic/seg_shift.sv
// serial segment driver; refreshes an eight-digit shift register display from a 32-bit word
`timescale 1ns/1ps

module seg_shift #(
    parameter int seg_div = 4
) (
    input  logic                               clk200m,
    input  logic                               rst_n,
    input  logic [kbd_seg_pkg::seg_width-1:0]  seg_wdata,
    output logic                               seg_clk,
    output logic                               seg_clr_n,
    output logic                               seg_dout,
    output logic                               seg_en
);

    // one digit per nibble
    localparam int digits  = kbd_seg_pkg::seg_width / 4;
    localparam int frame_w = digits * kbd_seg_pkg::digit_bits;
    localparam int bit_w   = $clog2(frame_w);
    localparam int div_w   = (seg_div > 1) ? $clog2(seg_div) : 1;

    logic [div_w-1:0]   div_cnt;
    logic               tick;
    logic [bit_w-1:0]   bit_cnt;
    logic [frame_w-1:0] frame_pat;
    // bits still to go, msb next
    logic [frame_w-1:0] shift_reg;

    // half period prescaler
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign tick = (div_cnt == div_w'(seg_div - 1));

    // font lookup per nibble, digit 7 lands in the top byte
    always_comb begin
        for (int i = 0; i < digits; i++) begin
            frame_pat[i*kbd_seg_pkg::digit_bits +: kbd_seg_pkg::digit_bits] =
                kbd_seg_pkg::seg_font(seg_wdata[i*4 +: 4]);
        end
    end

    // seg_en low is the gap half period, clock high half holds data steady
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            seg_clk  <= 1'b0;
            seg_en   <= 1'b0;
            seg_dout <= 1'b0;
            bit_cnt  <= '0;
        end else if (tick) begin
            if (!seg_en) begin
                // frame start, first bit goes out with the clock low
                seg_en   <= 1'b1;
                seg_clk  <= 1'b0;
                bit_cnt  <= '0;
                seg_dout <= frame_pat[frame_w-1];
            end else if (!seg_clk) begin
                // rising edge, display samples here
                seg_clk <= 1'b1;
            end else begin
                seg_clk <= 1'b0;
                if (bit_cnt == bit_w'(frame_w - 1)) begin
                    // last bit done, enter gap
                    seg_en   <= 1'b0;
                    seg_dout <= 1'b0;
                end else begin
                    bit_cnt  <= bit_cnt + 1'b1;
                    seg_dout <= shift_reg[frame_w-1];
                end
            end
        end
    end

    // word sampled once per frame
    always_ff @(posedge clk200m) begin
        if (tick) begin
            if (!seg_en) begin
                shift_reg <= {frame_pat[frame_w-2:0], 1'b0};
            end else if (seg_clk) begin
                shift_reg <= {shift_reg[frame_w-2:0], 1'b0};
            end
        end
    end

    // display clear follows system reset
    assign seg_clr_n = rst_n;

endmodule

// File: tb/kbd_seg_sva.sv
// bound checks on display driver serial timing and the keyboard queue read strobe
`timescale 1ns/1ps

module seg_shift_sva #(
    parameter int seg_div = 1
) (
    input logic clk200m,
    input logic rst_n,
    input logic seg_clk,
    input logic seg_dout,
    input logic seg_en,
    input logic rd_kb_n,
    input logic kb_ready
);

    // failures seen by this instance, read at the end of the run
    int fail_count = 0;

    // display shifts on rising seg_clk, so data holds through the high half
    a_dout_stable: assert property (@(posedge clk200m) disable iff (!rst_n)
        seg_clk |-> $stable(seg_dout))
        else begin
            fail_count++;
            $error("seg_dout moved while seg_clk was high");
        end

    // gap is exactly one half period long
    a_gap_len: assert property (@(posedge clk200m) disable iff (!rst_n)
        $fell(seg_en) |-> ##(seg_div - 1) !seg_en ##1 seg_en)
        else begin
            fail_count++;
            $error("seg_en gap not one half period");
        end

    // shift clock and data parked in the gap
    a_gap_idle: assert property (@(posedge clk200m) disable iff (!rst_n)
        !seg_en |-> (!seg_clk && !seg_dout))
        else begin
            fail_count++;
            $error("seg_clk or seg_dout active with seg_en low");
        end

    a_read_ready: assert property (@(posedge clk200m) disable iff (!rst_n)
        !rd_kb_n |-> kb_ready)
        else begin
            fail_count++;
            $error("rd_kb_n strobed with an empty queue");
        end

endmodule

// display side, strobe pair tied quiet
bind seg_shift seg_shift_sva #(.seg_div(seg_div)) u_shift_sva (
    .clk200m  (clk200m),
    .rst_n    (rst_n),
    .seg_clk  (seg_clk),
    .seg_dout (seg_dout),
    .seg_en   (seg_en),
    .rd_kb_n  (1'b1),
    .kb_ready (1'b1)
);

// receiver side, serial lines tied idle
bind ps2_kbd seg_shift_sva u_kbd_sva (
    .clk200m  (clk200m),
    .rst_n    (rst_n),
    .seg_clk  (1'b0),
    .seg_dout (1'b0),
    .seg_en   (1'b0),
    .rd_kb_n  (rd_kb_n),
    .kb_ready (kb_ready)
);

// File: tb/kbd_seg_tb.sv
// testbench for the keyboard to display top; sends ps/2 frames, models the display word, checks by assertions
`timescale 1ns/1ps

module kbd_seg_tb;

    // ps/2 half period in clk200m cycles
    localparam int ps2_half   = 8;
    // a display frame is 258 cycles at seg_div 2
    localparam int frame_wait = 2000;

    logic        clk200m;
    logic        rst_n;
    logic        ps2_clk;
    logic        ps2_data;
    logic [7:0]  leds;
    logic        seg_clk;
    logic        seg_clr_n;
    logic        seg_dout;
    logic        seg_en;

    // reference model state
    logic [31:0] exp_word;
    logic        exp_skip;
    // one-cycle strobes that arm the checks
    logic        stop_fall;
    logic        disp_check;
    // serial capture of the display stream
    logic [63:0] cap_shift = '0;
    logic [63:0] cap_frame = '0;
    int          cap_bits = 0;
    int          frames_seen = 0;

    int          err_reset;
    int          err_leds;
    int          err_disp;
    int          err_timeout;
    integer      seed;
    bit          ok;

    kbd_seg_top #(
        .fifo_depth (8),
        .seg_div    (2)
    ) u_dut (
        .clk200m    (clk200m),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .leds       (leds),
        .seg_clk    (seg_clk),
        .seg_clr_n  (seg_clr_n),
        .seg_dout   (seg_dout),
        .seg_en     (seg_en)
    );

    initial begin
        clk200m = 1'b0;
        forever #5 clk200m = ~clk200m;
    end

    // active-low gfedcba with dp dark, written out per digit
    function automatic logic [7:0] digit_pattern(input logic [3:0] nib);
        logic [7:0] pat;
        case (nib)
            4'h0: pat = 8'hC0;
            4'h1: pat = 8'hF9;
            4'h2: pat = 8'hA4;
            4'h3: pat = 8'hB0;
            4'h4: pat = 8'h99;
            4'h5: pat = 8'h92;
            4'h6: pat = 8'h82;
            4'h7: pat = 8'hF8;
            4'h8: pat = 8'h80;
            4'h9: pat = 8'h90;
            4'hA: pat = 8'h88;
            4'hB: pat = 8'h83;
            4'hC: pat = 8'hC6;
            4'hD: pat = 8'hA1;
            4'hE: pat = 8'h86;
            default: pat = 8'h8E;
        endcase
        return pat;
    endfunction

    // digit 7 in the top byte, so it is the first byte on the wire
    function automatic logic [63:0] expected_frame(input logic [31:0] word);
        logic [63:0] pat;
        for (int d = 0; d < 8; d++) begin
            pat[d*8 +: 8] = digit_pattern(word[d*4 +: 4]);
        end
        return pat;
    endfunction

    // rebuild each frame, first bit ends up in bit 63
    always @(posedge seg_clk or negedge seg_en) begin
        if (!seg_en) begin
            if (cap_bits == 64) begin
                cap_frame   <= cap_shift;
                frames_seen <= frames_seen + 1;
            end
            cap_bits <= 0;
        end else begin
            cap_shift <= {cap_shift[62:0], seg_dout};
            cap_bits  <= cap_bits + 1;
        end
    end

    a_reset_idle: assert property (@(posedge clk200m)
        (!rst_n || $rose(rst_n)) |-> (!seg_clk && !seg_en && !seg_dout && leds == 8'h00))
        else begin
            err_reset++;
            $display("[ERROR] %0t: outputs not idle around reset", $time);
        end

    a_clr_follows: assert property (@(posedge clk200m) seg_clr_n == rst_n)
        else begin
            err_reset++;
            $display("[ERROR] %0t: seg_clr_n %b with rst_n %b", $time,
                     $sampled(seg_clr_n), $sampled(rst_n));
        end

    // stop bit to leds within eight cycles
    a_leds_latency: assert property (@(posedge clk200m) stop_fall |-> ##8 (leds == exp_word[7:0]))
        else begin
            err_leds++;
            $display("[ERROR] %0t: leds %h, expected %h", $time, $sampled(leds), exp_word[7:0]);
        end

    a_display: assert property (@(posedge clk200m)
        disp_check |-> (cap_frame == expected_frame(exp_word)))
        else begin
            err_disp++;
            $display("[ERROR] %0t: display frame %h, expected %h", $time,
                     cap_frame, expected_frame(exp_word));
        end

    // inputs move 1 ns after the rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk200m);
        #1;
    endtask

    // controller rule: E0 dropped, F0 swallows the next byte, rest shifts in low
    task automatic model_byte(input logic [7:0] code);
        if (exp_skip) begin
            exp_skip = 1'b0;
        end else if (code == kbd_seg_pkg::code_break) begin
            exp_skip = 1'b1;
        end else if (code != kbd_seg_pkg::code_ext) begin
            exp_word = {exp_word[23:0], code};
        end
    endtask

    // start, eight data bits lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] code, input bit bad_parity, input int gap);
        logic [10:0] bits;
        logic        par;
        par  = ~(^code) ^ bad_parity;
        bits = {1'b1, par, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            step(ps2_half);
            ps2_clk = 1'b0;
            if (i == 10) begin
                stop_fall = 1'b1;
                if (!bad_parity) begin
                    model_byte(code);
                end
            end
            step(1);
            stop_fall = 1'b0;
            step(ps2_half - 1);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        step(gap);
    endtask

    task automatic random_code(output logic [7:0] code);
        code = 8'($random(seed));
        while (code == kbd_seg_pkg::code_break || code == kbd_seg_pkg::code_ext) begin
            code = 8'($random(seed));
        end
    endtask

    // second completed frame is the first one to start after the call
    task automatic check_display(output bit done);
        int start;
        int waited;
        start  = frames_seen;
        waited = 0;
        while (frames_seen < start + 2 && waited < frame_wait) begin
            step(1);
            waited++;
        end
        if (frames_seen < start + 2) begin
            err_timeout++;
            $display("timeout: no complete display frame within %0d cycles", frame_wait);
            done = 1'b0;
        end else begin
            disp_check = 1'b1;
            step(1);
            disp_check = 1'b0;
            done = 1'b1;
        end
    endtask

    task automatic end_run();
        int sva_errs;
        int total;
        sva_errs = u_dut.u_seg_shift.u_shift_sva.fail_count
                   + u_dut.u_ps2_kbd.u_kbd_sva.fail_count;
        total = err_reset + err_leds + err_disp + err_timeout + sva_errs;
        $display("errors: reset %0d, leds %0d, display %0d, timeout %0d, bound %0d",
                 err_reset, err_leds, err_disp, err_timeout, sva_errs);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        logic [7:0] code;
        rst_n       = 1'b1;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        stop_fall   = 1'b0;
        disp_check  = 1'b0;
        exp_word    = '0;
        exp_skip    = 1'b0;
        err_reset   = 0;
        err_leds    = 0;
        err_disp    = 0;
        err_timeout = 0;
        seed        = 32'habc7;
        ok          = 1'b1;
        // clean falling edge, then eight clocks in reset
        #1 rst_n = 1'b0;
        step(8);
        rst_n = 1'b1;
        step(10);

        send_frame(8'h1C, 1'b0, 20);
        // bad parity, dropped by the receiver
        send_frame(8'h32, 1'b1, 20);
        // key release, code swallowed
        send_frame(kbd_seg_pkg::code_break, 1'b0, 20);
        send_frame(8'h4D, 1'b0, 20);
        // extended make, only the code counts
        send_frame(kbd_seg_pkg::code_ext, 1'b0, 20);
        send_frame(8'h75, 1'b0, 20);

        repeat (6) begin
            random_code(code);
            send_frame(code, 1'b0, 20);
        end
        check_display(ok);

        // no idle time between frames, last one settles
        if (ok) begin
            for (int i = 0; i < 5; i++) begin
                random_code(code);
                send_frame(code, 1'b0, (i == 4) ? 20 : 0);
            end
            check_display(ok);
        end
        end_run();
    end

endmodule
